// ==== hw/ac_ctrl.sv ====
/* Frame control: processing flag, time window, output row counting,
   frame-done detection and start/end write-back to the register file */

`timescale 1ns/1ps

`include "ac_params.svh"

module ac_ctrl (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              upstart,
	input  logic              upend,
	input  logic              fin_tvalid,
	input  logic              fin_tready,
	input  logic              fin_tlast,
	output logic              processing,
	output logic              time_window,
	output logic              frame_done,
	output logic              crf_wrt,
	output ac_pkg::crf_data_t crf_wdata
);
	import ac_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	row_cnt_t    row_cnt;
	logic        row_done;
	logic        start_req;
	logic        clr_start;
	logic        set_end;

	// A row is finished when the last word of it leaves on the final stream
	assign row_done   = fin_tvalid & fin_tready & fin_tlast;
	assign frame_done = row_done & (row_cnt == row_cnt_t'(`AC_DST_H - 1));

	assign processing = (state != IDLE);

	// Host raised start with end clear and nothing is running yet
	assign start_req = upstart & ~upend & ~processing;

	// First write-back clears start, second one sets end
	assign clr_start = processing & frame_done & upstart;
	assign set_end   = (state == CLEAR_START) & ~upstart & ~upend;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE:
				if (start_req)
					state_nxt = RUN;
			RUN:
				if (clr_start)
					state_nxt = CLEAR_START;
			CLEAR_START:
				if (set_end)
					state_nxt = SET_END;
			// SET_END holds until the host sees the end bit
			default:
				state_nxt = state;
		endcase
		// End set with start clear finishes the frame from any active state
		if (processing & ~upstart & upend)
			state_nxt = IDLE;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	// Up-sampler may only write between start and frame end
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			time_window <= 1'b0;
		else if (start_req & ~time_window)
			time_window <= 1'b1;
		else if (clr_start)
			time_window <= 1'b0;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			row_cnt <= '0;
		else if (frame_done)
			row_cnt <= '0;
		else if (row_done)
			row_cnt <= row_cnt + 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			crf_wrt <= 1'b0;
		else
			crf_wrt <= clr_start | set_end;
	end

	// Bit 0 is start, bit 1 is end
	always_ff @(posedge clk) begin
		if (clr_start)
			crf_wdata <= {{(`AC_CRF_W - 2){1'b0}}, upend, 1'b0};
		else if (set_end)
			crf_wdata <= crf_data_t'(2);
	end

endmodule

// ==== hw/ac_outbuf.sv ====
/* Output FIFO for up-sampler words, with a registered head word and a frame clear */

`timescale 1ns/1ps

`include "ac_params.svh"

module ac_outbuf #(
	parameter int DEPTH = `AC_FIFO_DEPTH
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              clear,
	input  logic              wvalid,
	input  ac_pkg::pix_word_t wdata,
	input  logic              window,
	input  logic              rd,
	output logic              wready,
	output logic              empty,
	output ac_pkg::pix_word_t rdata
);
	import ac_pkg::*;

	localparam int AW = $clog2(DEPTH);

	pix_word_t     mem [DEPTH];
	logic [AW:0]   wr_ptr;
	logic [AW:0]   rd_ptr;
	logic          mem_empty;
	logic          mem_full;
	logic          head_valid;
	logic          head_load;
	logic          wr_en;
	logic          hold_full;

	assign mem_empty = (wr_ptr == rd_ptr);
	assign mem_full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	// Looks full for one cycle after reset
	assign wready = ~mem_full & ~hold_full;

	// Words offered outside the window are dropped
	assign wr_en = wvalid & wready & window;

	// Refill the head register when it is free or being read
	assign head_load = ~mem_empty & (~head_valid | rd);

	assign empty = ~head_valid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			hold_full <= 1'b1;
		else
			hold_full <= 1'b0;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			head_valid <= 1'b0;
		end else if (clear) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			head_valid <= 1'b0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (head_load) begin
				rd_ptr     <= rd_ptr + 1'b1;
				head_valid <= 1'b1;
			end else if (rd) begin
				head_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr[AW-1:0]] <= wdata;
		if (head_load)
			rdata <= mem[rd_ptr[AW-1:0]];
	end

endmodule

// ==== hw/ac_params.svh ====
/* Image, pixel, FIFO and register-file sizes for the access-control block */

`ifndef AC_PARAMS_SVH
`define AC_PARAMS_SVH

// Pixel format and packing
`define AC_PIX_W        24
`define AC_PIX_PER_WORD 2
`define AC_WORD_W       (`AC_PIX_W * `AC_PIX_PER_WORD)

// Small output image so simulation stays short
`define AC_DST_W        8
`define AC_DST_H        4

// Words per output row
`define AC_ROW_WORDS    (`AC_DST_W / `AC_PIX_PER_WORD)

// Power-of-two output FIFO depth in words
`define AC_FIFO_DEPTH   8

// Config register file data width
`define AC_CRF_W        32

`endif

// ==== hw/ac_pkg.sv ====
/* Shared types: stream word, row and column counters, register data, control states */

`include "ac_params.svh"

package ac_pkg;

	// One stream word with pixel 0 in the low bits
	typedef logic [`AC_WORD_W-1:0] pix_word_t;

	// Finished output rows within a frame
	typedef logic [$clog2(`AC_DST_H + 1)-1:0] row_cnt_t;

	// Words read within the current row
	typedef logic [$clog2(`AC_ROW_WORDS + 1)-1:0] col_cnt_t;

	// Write data towards the config register file
	typedef logic [`AC_CRF_W-1:0] crf_data_t;

	// Frame control sequence
	typedef enum logic [1:0] {
		IDLE,
		RUN,
		CLEAR_START,
		SET_END
	} ctrl_state_t;

endpackage

// ==== hw/ac_stream_out.sv ====
/* Stream master side: FIFO read control, row word counting,
   registered valid, last and pixel-reversed data */

`timescale 1ns/1ps

`include "ac_params.svh"

module ac_stream_out (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              clear,
	input  logic              window,
	input  logic              empty,
	input  ac_pkg::pix_word_t rdata,
	input  logic              m_tready,
	output logic              rd,
	output logic              m_tvalid,
	output ac_pkg::pix_word_t m_tdata,
	output logic              m_tlast
);
	import ac_pkg::*;

	col_cnt_t  col_cnt;
	logic      row_end;
	pix_word_t rev_data;

	// Pull a word when the output slot is free or emptying this cycle
	assign rd = ~empty & window & (~m_tvalid | m_tready);

	// Word being read is the last one of its row
	assign row_end = (col_cnt == col_cnt_t'(`AC_ROW_WORDS - 1));

	// Output pixel i takes stored pixel PIX_PER_WORD-1-i
	always_comb begin
		for (int i = 0; i < `AC_PIX_PER_WORD; i++) begin
			rev_data[i*`AC_PIX_W +: `AC_PIX_W] =
				rdata[(`AC_PIX_PER_WORD - 1 - i)*`AC_PIX_W +: `AC_PIX_W];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			col_cnt <= '0;
		else if (clear)
			col_cnt <= '0;
		else if (rd) begin
			if (row_end)
				col_cnt <= '0;
			else
				col_cnt <= col_cnt + 1'b1;
		end
	end

	// Valid and last hold until the sink accepts
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_tvalid <= 1'b0;
			m_tlast  <= 1'b0;
		end else if (rd) begin
			m_tvalid <= 1'b1;
			m_tlast  <= row_end;
		end else if (m_tready) begin
			m_tvalid <= 1'b0;
			m_tlast  <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd)
			m_tdata <= rev_data;
	end

endmodule

// ==== hw/access_control.sv ====
/* Access-control top level: frame control, output FIFO and stream master */

`timescale 1ns/1ps

`include "ac_params.svh"

module access_control (
	input  logic              clk,
	input  logic              rst_n,

	// Config register file
	input  logic              upstart,
	input  logic              upend,
	output logic              crf_wrt,
	output ac_pkg::crf_data_t crf_wdata,
	output logic              processing,

	// Up-sampler write side
	input  logic              upsp_wvalid,
	input  ac_pkg::pix_word_t upsp_wdata,
	output logic              upsp_wready,
	output logic              upsp_reset,

	// Stream master
	output logic              m_tvalid,
	output ac_pkg::pix_word_t m_tdata,
	output logic              m_tlast,
	input  logic              m_tready,

	// Final output stream, observed only
	input  logic              fin_tvalid,
	input  logic              fin_tready,
	input  logic              fin_tlast
);
	import ac_pkg::*;

	logic      time_window;
	logic      frame_done;
	logic      buf_empty;
	logic      buf_rd;
	pix_word_t buf_rdata;

	// Frame end also restarts the up-sampler
	assign upsp_reset = frame_done;

	ac_ctrl ctrl_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.upstart     (upstart),
		.upend       (upend),
		.fin_tvalid  (fin_tvalid),
		.fin_tready  (fin_tready),
		.fin_tlast   (fin_tlast),
		.processing  (processing),
		.time_window (time_window),
		.frame_done  (frame_done),
		.crf_wrt     (crf_wrt),
		.crf_wdata   (crf_wdata)
	);

	ac_outbuf #(
		.DEPTH (`AC_FIFO_DEPTH)
	) outbuf_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.clear  (frame_done),
		.wvalid (upsp_wvalid),
		.wdata  (upsp_wdata),
		.window (time_window),
		.rd     (buf_rd),
		.wready (upsp_wready),
		.empty  (buf_empty),
		.rdata  (buf_rdata)
	);

	ac_stream_out stream_out_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.clear    (frame_done),
		.window   (time_window),
		.empty    (buf_empty),
		.rdata    (buf_rdata),
		.m_tready (m_tready),
		.rd       (buf_rd),
		.m_tvalid (m_tvalid),
		.m_tdata  (m_tdata),
		.m_tlast  (m_tlast)
	);

endmodule

// ==== sources.f ====
+incdir+hw
hw/ac_pkg.sv
hw/ac_ctrl.sv
hw/ac_outbuf.sv
hw/ac_stream_out.sv
hw/access_control.sv
test/tb_clkgen.sv
test/ac_asserts.sv
test/tb_access_control.sv

// ==== test/ac_asserts.sv ====
/* Stream, write-back and up-sampler reset protocol assertions, bound to access_control */

`timescale 1ns/1ps

module ac_asserts (
	input logic              clk,
	input logic              rst_n,
	input logic              m_tvalid,
	input logic              m_tready,
	input ac_pkg::pix_word_t m_tdata,
	input logic              m_tlast,
	input logic              crf_wrt,
	input logic              processing,
	input logic              upsp_reset
);

	// A stalled beat keeps its payload
	stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
		m_tvalid && !m_tready |=> $stable(m_tdata) && $stable(m_tlast))
		else $error("m_tdata or m_tlast changed while the beat was stalled");

	wrt_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
		crf_wrt |-> processing)
		else $error("register write-back issued while not processing");

	reset_single: assert property (@(posedge clk) disable iff (!rst_n)
		upsp_reset |=> !upsp_reset)
		else $error("upsp_reset stayed high for more than one cycle");

	valid_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
		m_tvalid |-> processing)
		else $error("m_tvalid high while not processing");

endmodule

bind access_control ac_asserts asserts_i (
	.clk        (clk),
	.rst_n      (rst_n),
	.m_tvalid   (m_tvalid),
	.m_tready   (m_tready),
	.m_tdata    (m_tdata),
	.m_tlast    (m_tlast),
	.crf_wrt    (crf_wrt),
	.processing (processing),
	.upsp_reset (upsp_reset)
);

// ==== test/tb_access_control.sv ====
/* Table-driven testbench for access_control: register-file model,
   up-sampler writer, stream sink with back-pressure and frame-end checks */

`timescale 1ns/1ps

`include "ac_params.svh"

module tb_access_control;
	import ac_pkg::*;

	localparam int N_WORDS = `AC_DST_H * `AC_ROW_WORDS;
	localparam int LIMIT   = 400;

	typedef struct packed {
		pix_word_t din;
		pix_word_t dout;
		logic      last;
	} frame_entry_t;

	logic         clk;
	logic         rst_n;
	logic [1:0]   crf_reg;
	logic         crf_wrt;
	crf_data_t    crf_wdata;
	logic         processing;
	logic         upsp_wvalid;
	pix_word_t    upsp_wdata;
	logic         upsp_wready;
	logic         upsp_reset;
	logic         m_tvalid;
	pix_word_t    m_tdata;
	logic         m_tlast;
	logic         m_tready;
	frame_entry_t frame_tab [N_WORDS];
	logic [1:0]   crf_hist [$];
	int           err_cnt;
	int           check_cnt;
	int           out_idx;
	int           rst_pulses;
	int           rst_at;
	logic         rst_on_hs;

	tb_clkgen clkgen_i (
		.clk   (clk),
		.rst_n (rst_n)
	);

	// Bit 0 of the register is start, bit 1 is end; the final stream mirrors m_*
	access_control dut_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.upstart     (crf_reg[0]),
		.upend       (crf_reg[1]),
		.crf_wrt     (crf_wrt),
		.crf_wdata   (crf_wdata),
		.processing  (processing),
		.upsp_wvalid (upsp_wvalid),
		.upsp_wdata  (upsp_wdata),
		.upsp_wready (upsp_wready),
		.upsp_reset  (upsp_reset),
		.m_tvalid    (m_tvalid),
		.m_tdata     (m_tdata),
		.m_tlast     (m_tlast),
		.m_tready    (m_tready),
		.fin_tvalid  (m_tvalid),
		.fin_tready  (m_tready),
		.fin_tlast   (m_tlast)
	);

	// Register file copies every write-back
	always @(negedge clk) begin
		if (rst_n && crf_wrt) begin
			crf_reg <= crf_wdata[1:0];
			crf_hist.push_back(crf_wdata[1:0]);
		end
	end

	always @(posedge clk) begin
		if (rst_n && upsp_reset) begin
			rst_pulses++;
			rst_at    = out_idx;
			rst_on_hs = m_tvalid & m_tready & m_tlast;
		end
	end

	task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
		input string what);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timed out at %0t while waiting for %s", $time, what);
		$display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
		$display("SOME TESTS FAILED");
		$finish;
	endtask

	// Random pixels; the expected word holds them in reverse order
	task automatic build_table();
		int unsigned rnd;
		for (int k = 0; k < N_WORDS; k++) begin
			for (int p = 0; p < `AC_PIX_PER_WORD; p++) begin
				rnd = $urandom();
				frame_tab[k].din[p*`AC_PIX_W +: `AC_PIX_W] = rnd[`AC_PIX_W-1:0];
				frame_tab[k].dout[(`AC_PIX_PER_WORD-1-p)*`AC_PIX_W +: `AC_PIX_W] =
					rnd[`AC_PIX_W-1:0];
			end
			frame_tab[k].last = ((k % `AC_ROW_WORDS) == `AC_ROW_WORDS - 1);
		end
	endtask

	task automatic check_idle(input string when);
		check_equal(processing, 1'b0, {"processing ", when});
		check_equal(crf_wrt, 1'b0, {"crf_wrt ", when});
		check_equal(upsp_reset, 1'b0, {"upsp_reset ", when});
		check_equal(m_tvalid, 1'b0, {"m_tvalid ", when});
		check_equal(m_tlast, 1'b0, {"m_tlast ", when});
	endtask

	task automatic wait_processing(input logic level);
		int cnt;
		cnt = 0;
		while (processing !== level) begin
			if (cnt == 20)
				stop_on_timeout("processing to change");
			@(negedge clk);
			cnt++;
		end
	endtask

	// Words offered while the window is closed must be dropped
	task automatic offer_outside_window(input int n);
		for (int k = 0; k < n; k++) begin
			@(negedge clk);
			upsp_wvalid = 1'b1;
			upsp_wdata  = pix_word_t'({$urandom(), $urandom()});
		end
		@(negedge clk);
		upsp_wvalid = 1'b0;
	endtask

	task automatic write_frame();
		int   idx;
		int   cnt;
		logic v;
		idx = 0;
		cnt = 0;
		while (idx < N_WORDS) begin
			if (cnt == LIMIT)
				stop_on_timeout("up-sampler writes to be accepted");
			@(negedge clk);
			cnt++;
			v = ($urandom_range(3) != 0);
			upsp_wvalid = v;
			upsp_wdata  = frame_tab[idx].din;
			// Taken on the coming rising edge
			if (v && upsp_wready && processing)
				idx++;
		end
		@(negedge clk);
		upsp_wvalid = 1'b0;
	endtask

	task automatic read_frame(input logic stall);
		int   cnt;
		logic r;
		cnt = 0;
		if (stall) begin
			// Sink held off until the FIFO fills up
			@(negedge clk);
			m_tready = 1'b0;
			while (upsp_wready) begin
				if (cnt == LIMIT)
					stop_on_timeout("upsp_wready to drop under back-pressure");
				@(negedge clk);
				cnt++;
			end
		end
		while (out_idx < N_WORDS) begin
			if (cnt == LIMIT)
				stop_on_timeout("output words on the stream");
			@(negedge clk);
			cnt++;
			r = ($urandom_range(3) != 0);
			m_tready = r;
			if (r && m_tvalid) begin
				check_equal(m_tdata, frame_tab[out_idx].dout,
					$sformatf("word %0d m_tdata", out_idx));
				check_equal(m_tlast, frame_tab[out_idx].last,
					$sformatf("word %0d m_tlast", out_idx));
				out_idx++;
			end
		end
	endtask

	task automatic run_frame(input logic stall);
		offer_outside_window(6);
		out_idx    = 0;
		rst_pulses = 0;
		rst_on_hs  = 1'b0;
		crf_hist.delete();
		// Host sets start with end clear
		@(negedge clk);
		crf_reg = 2'b01;
		wait_processing(1'b1);
		fork
			write_frame();
			read_frame(stall);
		join
		wait_processing(1'b0);
		check_equal(rst_pulses, 1, "upsp_reset pulse count");
		check_equal(rst_at, N_WORDS, "words seen at upsp_reset");
		check_equal(rst_on_hs, 1'b1, "upsp_reset on last handshake");
		check_equal(crf_hist.size(), 2, "register write-back count");
		check_equal(crf_hist[0], 2'b00, "first write-back");
		check_equal(crf_hist[1], 2'b10, "second write-back");
		check_equal(m_tvalid, 1'b0, "m_tvalid after frame");
	endtask

	initial begin
		int cnt;
		void'($urandom(32'hef2e));
		crf_reg     = 2'b00;
		upsp_wvalid = 1'b0;
		upsp_wdata  = '0;
		m_tready    = 1'b0;
		err_cnt     = 0;
		check_cnt   = 0;
		out_idx     = 0;
		rst_pulses  = 0;
		rst_at      = 0;
		rst_on_hs   = 1'b0;
		build_table();
		@(negedge clk);
		check_idle("in reset");
		check_equal(upsp_wready, 1'b0, "upsp_wready in reset");
		cnt = 0;
		while (rst_n !== 1'b1) begin
			if (cnt == 20)
				stop_on_timeout("reset release");
			@(negedge clk);
			cnt++;
		end
		check_idle("after reset");
		run_frame(1'b1);
		// Second frame proves counters and FIFO were cleared
		run_frame(1'b0);
		$display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== test/tb_clkgen.sv ====
/* Testbench clock and power-on reset */

`timescale 1ns/1ps

module tb_clkgen #(
	parameter int PERIOD     = 40,
	parameter int RST_CYCLES = 4
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Release on a falling edge, away from the active clock edge
	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n <= 1'b1;
	end

endmodule
